//--- verilog/clb_settings.svh
`ifndef CLB_SETTINGS_SVH
`define CLB_SETTINGS_SVH

// Blocks in the row
`define CLB_COUNT 4
`define CLB_ADDR_W 2

// Frame slots in the config FIFO
`define CFG_FIFO_DEPTH 2

// addr + 36-bit block config
`define CFG_FRAME_W 38

`endif

//--- verilog/clb_pkg.sv
`include "clb_settings.svh"

package clb_pkg;

   // One block's configuration from the MSB down
   typedef struct packed {
      logic [15:0] lut;
      logic [1:0]  comb_mode;  // 0 one 4-input, 1 two 3-input, 2/3 B-selected
      logic [2:0]  pin_sel_f;  // [2] A/B, [1] B/C, [0] C/DQ1
      logic [2:0]  pin_sel_g;  // [2] A/B, [1] B/C, [0] C/DQ2
      logic        dq_sel_f;   // 0 D, 1 Q
      logic        dq_sel_g;
      logic [1:0]  set_sel;    // 0 A, 1 F, else never
      logic [1:0]  rst_sel;    // 0 D, 1 G, else never
      logic [1:0]  en_sel;     // 0 G, 1 C, else K
      logic [1:0]  x_sel;      // 0 F, 1 G, else Q
      logic [1:0]  y_sel;      // 0 Q, 1 G, else F
   } clb_cfg_t;

   typedef struct packed {
      logic [`CLB_ADDR_W-1:0] addr;
      clb_cfg_t               cfg;
   } cfg_frame_t;

   // Power-up configuration of every block
   parameter clb_cfg_t clb_cfg_default = '{
      lut:       16'h0116,
      comb_mode: 2'd0,
      pin_sel_f: 3'b000,
      pin_sel_g: 3'b111,
      dq_sel_f:  1'b0,
      dq_sel_g:  1'b0,
      set_sel:   2'd2,
      rst_sel:   2'd2,
      en_sel:    2'd2,
      x_sel:     2'd0,
      y_sel:     2'd0
   };

endpackage

//--- verilog/cfg_deserializer.sv
`timescale 1ns/1ns
`include "clb_settings.svh"

module cfg_deserializer
(
   input  logic                  KLK,
   input  logic                  rst_n,
   input  logic                  cfg_bit,
   input  logic                  cfg_bit_valid,
   output logic                  cfg_bit_ready,
   output clb_pkg::cfg_frame_t   frame,
   output logic                  frame_valid,
   input  logic                  frame_ready
);

   localparam int FRAME_W = `CFG_FRAME_W;
   localparam int CNT_W   = $clog2(FRAME_W);

   logic [FRAME_W-1:0] shift_q;
   logic [CNT_W-1:0]   bit_cnt;
   logic               take;

   // Stall the serial side while a finished frame waits
   assign cfg_bit_ready = ~frame_valid;
   assign take          = cfg_bit_valid & cfg_bit_ready;
   assign frame         = shift_q;

   // MSB first, address leads
   always_ff @(posedge KLK)
   begin
      if (take)
      begin
         shift_q <= {shift_q[FRAME_W-2:0], cfg_bit};
      end
   end

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         bit_cnt     <= '0;
         frame_valid <= 1'b0;
      end
      else
      begin
         if (take)
         begin
            if (bit_cnt == CNT_W'(FRAME_W - 1))
            begin
               bit_cnt     <= '0;
               frame_valid <= 1'b1;  // last bit in
            end
            else
            begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
         else if (frame_valid && frame_ready)
         begin
            frame_valid <= 1'b0;
         end
      end
   end

   // Held frame must not move until the FIFO takes it
   frame_hold_a: assert property (
      @(posedge KLK) disable iff (!rst_n)
      frame_valid && !frame_ready |=> frame_valid && $stable(frame)
   );

endmodule

//--- verilog/cfg_frame_fifo.sv
`timescale 1ns/1ns
`include "clb_settings.svh"

module cfg_frame_fifo
(
   input  logic                  KLK,
   input  logic                  rst_n,
   input  clb_pkg::cfg_frame_t   in_frame,
   input  logic                  in_valid,
   output logic                  in_ready,
   output clb_pkg::cfg_frame_t   out_frame,
   output logic                  out_valid,
   input  logic                  out_ready
);

   localparam int DEPTH = `CFG_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

   clb_pkg::cfg_frame_t mem [DEPTH];
   logic [PTR_W-1:0]    rd_ptr;
   logic [PTR_W-1:0]    wr_ptr;
   logic [CNT_W-1:0]    count;
   logic                push;
   logic                pop;

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;
   assign out_frame = mem[rd_ptr];

   always_ff @(posedge KLK)
   begin
      if (push)
      begin
         mem[wr_ptr] <= in_frame;
      end
   end

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle or both
         endcase
      end
   end

   count_bound_a: assert property (
      @(posedge KLK) disable iff (!rst_n)
      count <= CNT_W'(DEPTH)
   );

endmodule

//--- verilog/cfg_writer.sv
`timescale 1ns/1ns
`include "clb_settings.svh"

module cfg_writer
(
   input  logic                                  KLK,
   input  logic                                  rst_n,
   input  clb_pkg::cfg_frame_t                   frame,
   input  logic                                  frame_valid,
   input  logic                                  cfg_freeze,
   output logic                                  frame_ready,
   output clb_pkg::clb_cfg_t [`CLB_COUNT-1:0]    clb_cfg,
   output logic [`CLB_COUNT-1:0]                 cfg_loaded
);

   logic pop;

   // Frozen config leaves frames queued in the FIFO
   assign frame_ready = ~cfg_freeze;
   assign pop         = frame_valid & frame_ready;

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         clb_cfg    <= {`CLB_COUNT{clb_pkg::clb_cfg_default}};
         cfg_loaded <= '0;
      end
      else if (pop)
      begin
         clb_cfg[frame.addr]    <= frame.cfg;
         cfg_loaded[frame.addr] <= 1'b1;  // sticky
      end
   end

   // A freeze must hold every block config and load flag
   freeze_hold_a: assert property (
      @(posedge KLK) disable iff (!rst_n)
      cfg_freeze |=> $stable(clb_cfg) && $stable(cfg_loaded)
   );

endmodule

//--- verilog/clb_cell.sv
`timescale 1ns/1ns

module clb_cell
(
   input  logic                KLK,
   input  logic                rst_n,
   input  clb_pkg::clb_cfg_t   cfg,
   input  logic                a,
   input  logic                b,
   input  logic                c,
   input  logic                d,
   input  logic                k,
   output logic                x,
   output logic                y
);

   logic       q;
   logic       dq1;
   logic       dq2;
   logic [3:0] idx_f;
   logic [3:0] idx_g;
   logic       f;
   logic       g;
   logic       set_in;
   logic       rst_in;
   logic       en;

   assign dq1 = cfg.dq_sel_f ? q : d;
   assign dq2 = cfg.dq_sel_g ? q : d;

   always_comb
   begin
      case (cfg.comb_mode)
         2'd0:
         begin
            idx_f = {a, b, c, dq1};  // one 4-input function
            idx_g = idx_f;
         end
         2'd1:
         begin
            // F in the low half, G in the high half
            idx_f = {1'b0,
                     cfg.pin_sel_f[2] ? b : a,
                     cfg.pin_sel_f[1] ? c : b,
                     cfg.pin_sel_f[0] ? dq1 : c};
            idx_g = {1'b1,
                     cfg.pin_sel_g[2] ? b : a,
                     cfg.pin_sel_g[1] ? c : b,
                     cfg.pin_sel_g[0] ? dq2 : c};
         end
         default:
         begin
            idx_f = b ? {1'b1, a, c, dq2} : {1'b0, a, c, dq1};
            idx_g = idx_f;
         end
      endcase
   end

   assign f = cfg.lut[idx_f];
   assign g = cfg.lut[idx_g];

   assign set_in = (cfg.set_sel == 2'd0) ? a :
                   (cfg.set_sel == 2'd1) ? f : 1'b0;
   assign rst_in = (cfg.rst_sel == 2'd0) ? d :
                   (cfg.rst_sel == 2'd1) ? g : 1'b0;
   // Enable replaces the derived clock
   assign en     = (cfg.en_sel == 2'd0) ? g :
                   (cfg.en_sel == 2'd1) ? c : k;

   assign x = (cfg.x_sel == 2'd0) ? f :
              (cfg.x_sel == 2'd1) ? g : q;
   assign y = (cfg.y_sel == 2'd0) ? q :
              (cfg.y_sel == 2'd1) ? g : f;

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         q <= 1'b0;
      end
      else if (en)
      begin
         if (rst_in)
            q <= 1'b0;  // reset beats set
         else if (set_in)
            q <= 1'b1;
         else
            q <= f;
      end
   end

   // Mode 3 is never written by a valid bitstream
   mode_legal_a: assert property (
      @(posedge KLK) disable iff (!rst_n)
      cfg.comb_mode != 2'd3
   );

endmodule

//--- verilog/clb_array.sv
`timescale 1ns/1ns
`include "clb_settings.svh"

module clb_array
(
   input  logic                   KLK,
   input  logic                   rst_n,
   input  logic                   cfg_bit,
   input  logic                   cfg_bit_valid,
   input  logic                   cfg_freeze,
   output logic                   cfg_bit_ready,
   output logic [`CLB_COUNT-1:0]  cfg_loaded,
   input  logic [`CLB_COUNT-1:0]  pin_a,
   input  logic [`CLB_COUNT-1:0]  pin_b,
   input  logic [`CLB_COUNT-1:0]  pin_c,
   input  logic [`CLB_COUNT-1:0]  pin_d,
   input  logic [`CLB_COUNT-1:0]  pin_k,
   output logic [`CLB_COUNT-1:0]  pin_x,
   output logic [`CLB_COUNT-1:0]  pin_y
);

   clb_pkg::cfg_frame_t                  des_frame;
   logic                                 des_valid;
   logic                                 des_ready;
   clb_pkg::cfg_frame_t                  fifo_frame;
   logic                                 fifo_valid;
   logic                                 fifo_ready;
   clb_pkg::clb_cfg_t [`CLB_COUNT-1:0]   clb_cfg;

   cfg_deserializer u_deser (
      .KLK           (KLK),
      .rst_n         (rst_n),
      .cfg_bit       (cfg_bit),
      .cfg_bit_valid (cfg_bit_valid),
      .cfg_bit_ready (cfg_bit_ready),
      .frame         (des_frame),
      .frame_valid   (des_valid),
      .frame_ready   (des_ready)
   );

   cfg_frame_fifo u_fifo (
      .KLK       (KLK),
      .rst_n     (rst_n),
      .in_frame  (des_frame),
      .in_valid  (des_valid),
      .in_ready  (des_ready),
      .out_frame (fifo_frame),
      .out_valid (fifo_valid),
      .out_ready (fifo_ready)
   );

   cfg_writer u_writer (
      .KLK         (KLK),
      .rst_n       (rst_n),
      .frame       (fifo_frame),
      .frame_valid (fifo_valid),
      .cfg_freeze  (cfg_freeze),
      .frame_ready (fifo_ready),
      .clb_cfg     (clb_cfg),
      .cfg_loaded  (cfg_loaded)
   );

   // One cell per column
   for (genvar i = 0; i < `CLB_COUNT; i++)
   begin : g_cell
      clb_cell u_cell (
         .KLK   (KLK),
         .rst_n (rst_n),
         .cfg   (clb_cfg[i]),
         .a     (pin_a[i]),
         .b     (pin_b[i]),
         .c     (pin_c[i]),
         .d     (pin_d[i]),
         .k     (pin_k[i]),
         .x     (pin_x[i]),
         .y     (pin_y[i])
      );
   end

endmodule

//--- verif/tb_clb_array.sv
`timescale 1ns/1ns
`include "clb_settings.svh"

module tb_clb_array;

   logic                  KLK;
   logic                  rst_n;
   logic                  cfg_bit;
   logic                  cfg_bit_valid;
   logic                  cfg_freeze;
   logic                  cfg_bit_ready;
   logic [`CLB_COUNT-1:0] cfg_loaded;
   logic [`CLB_COUNT-1:0] pin_a;
   logic [`CLB_COUNT-1:0] pin_b;
   logic [`CLB_COUNT-1:0] pin_c;
   logic [`CLB_COUNT-1:0] pin_d;
   logic [`CLB_COUNT-1:0] pin_k;
   logic [`CLB_COUNT-1:0] pin_x;
   logic [`CLB_COUNT-1:0] pin_y;

   clb_pkg::clb_cfg_t     exp_cfg [`CLB_COUNT];
   logic                  exp_q [`CLB_COUNT];
   int                    errors;
   int unsigned           seed;

   clb_array DUT (
      .KLK           (KLK),
      .rst_n         (rst_n),
      .cfg_bit       (cfg_bit),
      .cfg_bit_valid (cfg_bit_valid),
      .cfg_freeze    (cfg_freeze),
      .cfg_bit_ready (cfg_bit_ready),
      .cfg_loaded    (cfg_loaded),
      .pin_a         (pin_a),
      .pin_b         (pin_b),
      .pin_c         (pin_c),
      .pin_d         (pin_d),
      .pin_k         (pin_k),
      .pin_x         (pin_x),
      .pin_y         (pin_y)
   );

   initial
   begin
      KLK = 1'b0;
      forever #5 KLK = ~KLK;
   end

   function automatic clb_pkg::clb_cfg_t make_cfg(input logic [15:0] lut,
      input logic [1:0] mode, input logic [2:0] psf, input logic [2:0] psg,
      input logic dqf, input logic dqg, input logic [1:0] set_s, input logic [1:0] rst_s,
      input logic [1:0] en_s, input logic [1:0] x_s, input logic [1:0] y_s);
      clb_pkg::clb_cfg_t cfg;
      cfg.lut       = lut;
      cfg.comb_mode = mode;
      cfg.pin_sel_f = psf;
      cfg.pin_sel_g = psg;
      cfg.dq_sel_f  = dqf;
      cfg.dq_sel_g  = dqg;
      cfg.set_sel   = set_s;
      cfg.rst_sel   = rst_s;
      cfg.en_sel    = en_s;
      cfg.x_sel     = x_s;
      cfg.y_sel     = y_s;
      return cfg;
   endfunction

   // Reference block returning {f, g, x, y, next q}
   function automatic logic [4:0] model_cell(input clb_pkg::clb_cfg_t cfg,
      input logic a, input logic b, input logic c, input logic d, input logic k,
      input logic q);
      logic       dq1;
      logic       dq2;
      logic [3:0] fi;
      logic [3:0] gi;
      logic       f;
      logic       g;
      logic       s;
      logic       r;
      logic       en;
      logic       qn;
      dq1 = cfg.dq_sel_f ? q : d;
      dq2 = cfg.dq_sel_g ? q : d;
      if (cfg.comb_mode == 2'd0)
      begin
         fi = {a, b, c, dq1};
         gi = fi;
      end
      else if (cfg.comb_mode == 2'd1)
      begin
         fi = {1'b0, cfg.pin_sel_f[2] ? b : a, cfg.pin_sel_f[1] ? c : b,
               cfg.pin_sel_f[0] ? dq1 : c};
         gi = {1'b1, cfg.pin_sel_g[2] ? b : a, cfg.pin_sel_g[1] ? c : b,
               cfg.pin_sel_g[0] ? dq2 : c};
      end
      else
      begin
         fi = {b, a, c, b ? dq2 : dq1};  // B picks the half
         gi = fi;
      end
      f  = cfg.lut[fi];
      g  = cfg.lut[gi];
      s  = (cfg.set_sel == 2'd0) ? a : (cfg.set_sel == 2'd1) ? f : 1'b0;
      r  = (cfg.rst_sel == 2'd0) ? d : (cfg.rst_sel == 2'd1) ? g : 1'b0;
      en = (cfg.en_sel == 2'd0) ? g : (cfg.en_sel == 2'd1) ? c : k;
      qn = !en ? q : r ? 1'b0 : s ? 1'b1 : f;
      return {f, g, (cfg.x_sel == 2'd0) ? f : (cfg.x_sel == 2'd1) ? g : q,
              (cfg.y_sel == 2'd0) ? q : (cfg.y_sel == 2'd1) ? g : f, qn};
   endfunction

   task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic apply_reset();
      int i;
      rst_n         = 1'b0;
      cfg_bit       = 1'b0;
      cfg_bit_valid = 1'b0;
      cfg_freeze    = 1'b0;
      pin_a         = '0;
      pin_b         = '0;
      pin_c         = '0;
      pin_d         = '0;
      pin_k         = '0;
      repeat (5) @(posedge KLK);
      #1;
      rst_n = 1'b1;
      for (i = 0; i < `CLB_COUNT; i++)
      begin
         exp_cfg[i] = make_cfg(16'h0116, 2'd0, 3'b000, 3'b111, 1'b0, 1'b0,
                               2'd2, 2'd2, 2'd2, 2'd0, 2'd0);
         exp_q[i]   = 1'b0;
      end
   endtask

   // One edge per call with outputs checked at the falling edge
   task automatic check_step(input logic [3:0] a, input logic [3:0] b, input logic [3:0] c,
      input logic [3:0] d, input logic [3:0] k);
      logic [4:0] r;
      int         i;
      @(posedge KLK);
      #1;
      pin_a = a;
      pin_b = b;
      pin_c = c;
      pin_d = d;
      pin_k = k;
      @(negedge KLK);
      for (i = 0; i < `CLB_COUNT; i++)
      begin
         r = model_cell(exp_cfg[i], a[i], b[i], c[i], d[i], k[i], exp_q[i]);
         check_value($sformatf("pin_x[%0d]", i), 8'(pin_x[i]), 8'(r[2]));
         check_value($sformatf("pin_y[%0d]", i), 8'(pin_y[i]), 8'(r[1]));
         exp_q[i] = r[0];
      end
   endtask

   task automatic sweep_inputs();
      int n;
      for (n = 0; n < 16; n++)
         check_step({4{n[3]}}, {4{n[2]}}, {4{n[1]}}, {4{n[0]}}, 4'h0);
   endtask

   task automatic wait_bit_ready();
      int n;
      n = 0;
      @(negedge KLK);
      while (!cfg_bit_ready && n < 200)
      begin
         @(negedge KLK);
         n++;
      end
      if (!cfg_bit_ready)
      begin
         errors++;
         $display("Timeout: cfg_bit_ready never rose for the next bit");
      end
   endtask

   task automatic send_frame(input logic [`CLB_ADDR_W-1:0] addr, input clb_pkg::clb_cfg_t cfg);
      logic [`CFG_FRAME_W-1:0] bits;
      int                      i;
      bits = {addr, cfg};
      for (i = `CFG_FRAME_W - 1; i >= 0; i--)
      begin
         @(posedge KLK);  // accepts the previous bit
         #1;
         cfg_bit       = bits[i];
         cfg_bit_valid = 1'b1;
         wait_bit_ready();
      end
      @(posedge KLK);
      #1;
      cfg_bit_valid = 1'b0;
   endtask

   task automatic load_block(input logic [`CLB_ADDR_W-1:0] addr, input clb_pkg::clb_cfg_t cfg);
      int n;
      send_frame(addr, cfg);
      n = 0;
      while (!cfg_loaded[addr] && n < 50)
      begin
         @(negedge KLK);
         n++;
      end
      if (!cfg_loaded[addr])
      begin
         errors++;
         $display("Timeout: block %0d never reported its configuration loaded", addr);
      end
      exp_cfg[addr] = cfg;
   endtask

   task automatic test_default();
      int n;
      apply_reset();
      @(negedge KLK);
      check_value("cfg_bit_ready", 8'(cfg_bit_ready), 8'h01);
      check_value("cfg_loaded", 8'(cfg_loaded), 8'h00);
      sweep_inputs();
      for (n = 0; n < 8; n++)
         check_step(4'($urandom()), 4'($urandom()), 4'($urandom()), 4'($urandom()), 4'hf);
   endtask

   task automatic test_mode0();
      int i;
      apply_reset();
      for (i = 0; i < `CLB_COUNT; i++)
         load_block(2'(i), make_cfg(16'($urandom()), 2'd0, 3'b000, 3'b000, 1'b0, 1'b0,
                                    2'd2, 2'd2, 2'd2, 2'd0, 2'd3));
      sweep_inputs();
   endtask

   task automatic test_mode1();
      int r;
      int i;
      for (r = 0; r < 2; r++)
      begin
         apply_reset();
         for (i = 0; i < `CLB_COUNT; i++)
            load_block(2'(i), make_cfg(16'($urandom()), 2'd1, 3'(r * 4 + i),
                                       3'(7 - r * 4 - i), i[0], i[1],
                                       2'd2, 2'd2, 2'd2, 2'd0, 2'd1));
         sweep_inputs();
      end
   endtask

   // Enables stay low while loading since all pins are 0 and lut[8] of block 0 is clear
   task automatic test_state();
      int n;
      apply_reset();
      load_block(2'd0, make_cfg(16'($urandom()) & 16'hfeff, 2'd1, 3'b001, 3'b010, 1'b1, 1'b0,
                                2'd0, 2'd0, 2'd0, 2'd2, 2'd1));
      load_block(2'd1, make_cfg(16'($urandom()), 2'd1, 3'b101, 3'b011, 1'b1, 1'b1,
                                2'd1, 2'd1, 2'd1, 2'd2, 2'd3));
      load_block(2'd2, make_cfg(16'($urandom()), 2'd0, 3'b000, 3'b000, 1'b1, 1'b0,
                                2'd0, 2'd0, 2'd3, 2'd0, 2'd0));
      load_block(2'd3, make_cfg(16'($urandom()), 2'd2, 3'b000, 3'b000, 1'b1, 1'b1,
                                2'd1, 2'd3, 2'd2, 2'd1, 2'd0));
      for (n = 0; n < 96; n++)
         check_step(4'($urandom()), 4'($urandom()), 4'($urandom()), 4'($urandom()),
                    4'($urandom()));
   endtask

   task automatic test_backpressure();
      clb_pkg::clb_cfg_t cfg_a;
      clb_pkg::clb_cfg_t cfg_b;
      clb_pkg::clb_cfg_t cfg_c;
      int                n;
      apply_reset();
      cfg_a     = make_cfg(16'($urandom()), 2'd0, 3'b000, 3'b000, 1'b0, 1'b0,
                           2'd2, 2'd2, 2'd2, 2'd0, 2'd1);
      cfg_b     = make_cfg(16'($urandom()), 2'd0, 3'b000, 3'b000, 1'b0, 1'b0,
                           2'd2, 2'd2, 2'd2, 2'd0, 2'd3);
      cfg_c     = cfg_a;
      cfg_c.lut = ~cfg_a.lut;  // later frame to block 0
      cfg_freeze = 1'b1;
      send_frame(2'd0, cfg_a);
      send_frame(2'd1, cfg_b);
      send_frame(2'd0, cfg_c);
      for (n = 0; n < 20; n++)
      begin
         @(negedge KLK);
         check_value("cfg_bit_ready", 8'(cfg_bit_ready), 8'h00);
         check_value("cfg_loaded", 8'(cfg_loaded), 8'h00);
      end
      @(posedge KLK);
      #1;
      cfg_freeze = 1'b0;
      // Frame to block 2 lands only after the queued ones
      load_block(2'd2, make_cfg(16'($urandom()), 2'd0, 3'b000, 3'b000, 1'b0, 1'b0,
                                2'd2, 2'd2, 2'd2, 2'd0, 2'd3));
      check_value("cfg_loaded", 8'(cfg_loaded), 8'h07);
      exp_cfg[0] = cfg_c;
      exp_cfg[1] = cfg_b;
      sweep_inputs();
   endtask

   initial
   begin
      errors = 0;
      seed   = $urandom(70835);
      test_default();
      test_mode0();
      test_mode1();
      test_state();
      test_backpressure();
      $display("Checks finished with %0d errors", errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- files.f
+incdir+verilog
verilog/clb_pkg.sv
verilog/cfg_deserializer.sv
verilog/cfg_frame_fifo.sv
verilog/cfg_writer.sv
verilog/clb_cell.sv
verilog/clb_array.sv
verif/tb_clb_array.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CLB array testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_clb_array -f files.f -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST RESULT: PASS" "$SIM_LOG"; then
   exit 0
fi

echo "Pass line not found in $SIM_LOG"
exit 1
